/* Bender.yml */
package:
  name: floo_reduction

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/floo_noc_pkg.sv
      - verilog/floo_resp_pkg.sv
      - verilog/floo_reduction_sync.sv
      - verilog/floo_reduction_arbiter.sv
      - verilog/floo_reduction_out_reg.sv
      - verilog/floo_reduction_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_floo_reduction_unit.sv

/* floo_reduction.f */
+incdir+verilog
verilog/floo_noc_pkg.sv
verilog/floo_resp_pkg.sv
verilog/floo_reduction_sync.sv
verilog/floo_reduction_arbiter.sv
verilog/floo_reduction_out_reg.sv
verilog/floo_reduction_unit.sv
verif/tb_floo_reduction_unit.sv

/* verif/tb_floo_reduction_unit.sv */
/*
 * Table-driven testbench for the B-response reduction unit.
 * Expected masks and merged flits come from a model of the XY and merge rules.
 * Flits left on unexpected routes are withdrawn when the next row starts.
 */
`timescale 1ns/1ps
`include "floo_red_macros.svh"

module tb_floo_reduction_unit;

  localparam int         NR       = `FLOO_RED_NUM_ROUTES;
  localparam int         NUM_ROWS = 12;
  localparam int         MAX_CYC  = 20 * NUM_ROWS + 20;
  localparam logic [1:0] OK       = floo_resp_pkg::RESP_OKAY;
  localparam logic [1:0] ER       = floo_resp_pkg::RESP_SLVERR;

  // One stimulus row with its expected results
  typedef struct packed {
    floo_noc_pkg::coord_t         xy;
    floo_noc_pkg::flit_t [NR-1:0] flit;
    logic [NR-1:0]                valid;
    // Partial set shown before the full group
    logic [NR-1:0]                wait_valid;
    logic [2:0]                   wait_cyc;
    // Route with a foreign txn_id while waiting, 7 for none
    logic [2:0]                   bad_route;
    // Cycles of ready_i low once the full group is shown
    logic [2:0]                   ready_low;
    // Output must leave one cycle after the previous one
    logic                         b2b;
    logic [NR-1:0]                exp_mask;
    logic [2:0]                   exp_route;
  } row_t;

  logic                         clk_i;
  logic                         arst_n_i;
  floo_noc_pkg::coord_t         xy_id_i;
  logic [NR-1:0]                valid_i;
  logic [NR-1:0]                ready_o;
  floo_noc_pkg::flit_t [NR-1:0] data_i;
  logic                         valid_o;
  logic                         ready_i;
  floo_noc_pkg::flit_t          data_o;

  row_t        tbl [NUM_ROWS];
  string       row_name [NUM_ROWS];
  int          row_err [NUM_ROWS];
  // Accepted rows in flight and their accept cycles
  int          pend_q [$];
  int          acc_q [$];
  logic [31:0] seed;
  int          cyc;
  int          err_cnt;
  int          tests_run;
  int          tests_pass;
  int          last_out;
  bit          head_seen;

  floo_reduction_unit uut (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .xy_id_i (xy_id_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic floo_noc_pkg::coord_t make_coord(input int x, input int y);
    floo_noc_pkg::coord_t c;
    c.x = x[2:0];
    c.y = y[2:0];
    return c;
  endfunction

  // Lowest valid index leads the group
  function automatic int lead_route(input logic [NR-1:0] v);
    for (int i = 0; i < NR; i++) begin
      if (v[i]) return i;
    end
    return 0;
  endfunction

  // Narrow code in payload bits 1:0, wide code in bits 9:8
  function automatic logic [1:0] resp_code(input floo_noc_pkg::flit_t f,
                                           input floo_noc_pkg::axi_ch_e ch);
    return (ch == floo_noc_pkg::NarrowB) ? f.payload[1:0] : f.payload[9:8];
  endfunction

  // Routes that owe a response at router r under XY routing
  function automatic logic [NR-1:0] expected_routes(input floo_noc_pkg::coord_t r,
                                                    input floo_noc_pkg::hdr_t h);
    int            rx;
    int            ry;
    int            sy;
    bit            in_x;
    bit            in_y;
    logic [NR-1:0] m;
    rx   = int'(r.x);
    ry   = int'(r.y);
    sy   = int'(h.src_id.y);
    in_x = (rx >= int'(h.region.x_lo)) && (rx <= int'(h.region.x_hi));
    in_y = (ry >= int'(h.region.y_lo)) && (ry <= int'(h.region.y_hi));
    m    = '0;
    m[floo_noc_pkg::Local] = in_x && in_y;
    if (ry == sy) begin
      m[floo_noc_pkg::East]  = int'(h.region.x_hi) > rx;
      m[floo_noc_pkg::West]  = int'(h.region.x_lo) < rx;
      m[floo_noc_pkg::North] = in_x && (int'(h.region.y_hi) > ry);
      m[floo_noc_pkg::South] = in_x && (int'(h.region.y_lo) < ry);
    end else if (ry > sy) begin
      m[floo_noc_pkg::North] = int'(h.region.y_hi) > ry;
    end else begin
      m[floo_noc_pkg::South] = int'(h.region.y_lo) < ry;
    end
    return m;
  endfunction

  // First expected SLVERR wins, else first expected route
  function automatic int merge_pick(input row_t row, input logic [NR-1:0] m);
    int                     pick;
    floo_noc_pkg::axi_ch_e  ch;
    ch   = row.flit[lead_route(row.valid)].hdr.axi_ch;
    pick = -1;
    for (int i = 0; i < NR; i++) begin
      if ((pick < 0) && m[i] && (resp_code(row.flit[i], ch) == ER)) pick = i;
    end
    for (int i = 0; i < NR; i++) begin
      if ((pick < 0) && m[i]) pick = i;
    end
    return pick;
  endfunction

  // Codes are packed {L, W, S, E, N}; other payload bits are random
  task automatic add_row(input int r, input string name, input int x, input int y,
                         input int sx, input int sy, input floo_noc_pkg::axi_ch_e ch,
                         input logic [NR-1:0] valid, input logic [2*NR-1:0] codes,
                         input logic [NR-1:0] wait_valid, input int wait_cyc,
                         input int bad_route, input int ready_low, input bit b2b,
                         input logic [NR-1:0] exp_mask, input int exp_route);
    floo_noc_pkg::hdr_t hdr;
    logic [15:0]        pl;
    hdr.src_id      = make_coord(sx, sy);
    hdr.region.x_lo = 3'd1;
    hdr.region.x_hi = 3'd4;
    hdr.region.y_lo = 3'd1;
    hdr.region.y_hi = 3'd5;
    hdr.txn_id      = r[3:0];
    hdr.axi_ch      = ch;
    row_name[r]          = name;
    tbl[r].xy            = make_coord(x, y);
    tbl[r].valid         = valid;
    tbl[r].wait_valid    = wait_valid;
    tbl[r].wait_cyc      = wait_cyc[2:0];
    tbl[r].bad_route     = bad_route[2:0];
    tbl[r].ready_low     = ready_low[2:0];
    tbl[r].b2b           = b2b;
    tbl[r].exp_mask      = exp_mask;
    tbl[r].exp_route     = exp_route[2:0];
    for (int i = 0; i < NR; i++) begin
      seed = lcg_next(seed);
      pl   = seed[31:16];
      if (ch == floo_noc_pkg::NarrowB) pl[1:0] = codes[2*i +: 2];
      else pl[9:8] = codes[2*i +: 2];
      tbl[r].flit[i].hdr     = hdr;
      tbl[r].flit[i].payload = pl;
    end
  endtask

  task automatic value_error(input string test, input int r, input string what,
                             input logic [63:0] exp_v, input logic [63:0] act_v);
    $display("** Error %s: %s expected %0h actual %0h", test, what, exp_v, act_v);
    err_cnt++;
    if (r >= 0) row_err[r]++;
  endtask

  task automatic plain_error(input string msg);
    $display("Error: %s", msg);
    err_cnt++;
  endtask

  task automatic close_test(input string test, input bit ok);
    $display("test %-20s %s", test, ok ? "PASS" : "FAIL");
    tests_run++;
    if (ok) tests_pass++;
  endtask

  // Called right after a rising edge, returns right after one
  task automatic apply_row(input int r);
    floo_noc_pkg::flit_t [NR-1:0] wdata;
    floo_noc_pkg::flit_t          held;
    bit                           accepted;
    wdata = tbl[r].flit;
    if (tbl[r].bad_route < NR) begin
      wdata[tbl[r].bad_route].hdr.txn_id = ~tbl[r].flit[0].hdr.txn_id;
    end
    xy_id_i <= tbl[r].xy;
    // Incomplete or mismatched set must not be acked
    if (tbl[r].wait_cyc != 0) begin
      valid_i <= tbl[r].wait_valid;
      data_i  <= wdata;
      ready_i <= 1'b1;
      repeat (tbl[r].wait_cyc) begin
        @(negedge clk_i);
        if (ready_o !== '0) value_error(row_name[r], r, "ready_o while waiting", 0, ready_o);
        @(posedge clk_i);
      end
    end
    valid_i <= tbl[r].valid;
    data_i  <= tbl[r].flit;
    ready_i <= (tbl[r].ready_low == 0);
    held    = '0;
    // Register full and stalled, previous result must hold
    for (int k = 0; k < tbl[r].ready_low; k++) begin
      @(negedge clk_i);
      if (k == 0) held = data_o;
      if (valid_o !== 1'b1) value_error(row_name[r], r, "valid_o under stall", 1, valid_o);
      if (data_o !== held) value_error(row_name[r], r, "data_o under stall", held, data_o);
      if (ready_o !== '0) value_error(row_name[r], r, "ready_o under stall", 0, ready_o);
      @(posedge clk_i);
    end
    ready_i  <= 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      if (ready_o !== '0) begin
        if (ready_o !== tbl[r].exp_mask) begin
          value_error(row_name[r], r, "ready_o mask", tbl[r].exp_mask, ready_o);
        end
        pend_q.push_back(r);
        acc_q.push_back(cyc);
        accepted = 1'b1;
      end
      @(posedge clk_i);
    end
  endtask

  // Output monitor, one cycle latency and merged flit content
  always @(negedge clk_i) begin
    int                  r;
    floo_noc_pkg::flit_t exp_flit;
    if (arst_n_i && (valid_o === 1'b1)) begin
      if (pend_q.size() == 0) begin
        plain_error("an output flit appeared without an accepted group");
      end else begin
        r = pend_q[0];
        if (!head_seen) begin
          head_seen = 1'b1;
          if (cyc != acc_q[0] + 1) value_error(row_name[r], r, "latency", 1, cyc - acc_q[0]);
        end
        if (ready_i === 1'b1) begin
          exp_flit = tbl[r].flit[tbl[r].exp_route];
          if (data_o !== exp_flit) value_error(row_name[r], r, "data_o", exp_flit, data_o);
          if (tbl[r].b2b && (cyc != last_out + 1)) begin
            value_error(row_name[r], r, "cycles since last output", 1, cyc - last_out);
          end
          last_out  = cyc;
          head_seen = 1'b0;
          void'(pend_q.pop_front());
          void'(acc_q.pop_front());
          close_test(row_name[r], row_err[r] == 0);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cyc++;
    if (cyc > MAX_CYC) begin
      $display("Timeout: the run made no progress within %0d cycles", MAX_CYC);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int            reset_err;
    logic [NR-1:0] m;
    int            w;
    arst_n_i   = 1'b0;
    ready_i    = 1'b0;
    valid_i    = '0;
    data_i     = '0;
    xy_id_i    = '0;
    seed       = 32'h2e2929c0;
    cyc        = 0;
    err_cnt    = 0;
    tests_run  = 0;
    tests_pass = 0;
    last_out   = 0;
    head_seen  = 1'b0;

    // Region x 1..4, y 1..5 in every row
    add_row(0, "src_row_center", 2, 3, 2, 3, floo_noc_pkg::NarrowB, 5'h1F,
            {OK, OK, OK, OK, OK}, 5'h00, 0, 7, 0, 0, 5'h1F, 0);
    add_row(1, "src_row_east_edge", 4, 3, 2, 3, floo_noc_pkg::WideB, 5'h1F,
            {OK, OK, OK, ER, OK}, 5'h00, 0, 7, 0, 0, 5'h1D, 0);
    add_row(2, "above_src_missing", 3, 4, 2, 3, floo_noc_pkg::NarrowB, 5'h11,
            {ER, OK, OK, OK, OK}, 5'h10, 3, 7, 0, 0, 5'h11, 4);
    add_row(3, "above_top_row", 3, 5, 2, 3, floo_noc_pkg::WideB, 5'h10,
            {OK, OK, OK, OK, OK}, 5'h00, 0, 7, 0, 0, 5'h10, 4);
    add_row(4, "below_src_txn", 2, 2, 2, 3, floo_noc_pkg::WideB, 5'h15,
            {ER, OK, ER, OK, ER}, 5'h14, 3, 2, 0, 0, 5'h14, 2);
    add_row(5, "outside_col_branch", 2, 0, 0, 0, floo_noc_pkg::WideB, 5'h1F,
            {OK, ER, ER, ER, OK}, 5'h00, 0, 7, 0, 0, 5'h0B, 1);
    add_row(6, "outside_src_row", 6, 3, 2, 3, floo_noc_pkg::NarrowB, 5'h18,
            {ER, OK, OK, OK, OK}, 5'h00, 0, 7, 0, 0, 5'h08, 3);
    add_row(7, "stall_held", 2, 3, 2, 3, floo_noc_pkg::NarrowB, 5'h1F,
            {OK, ER, OK, OK, OK}, 5'h00, 0, 7, 0, 0, 5'h1F, 3);
    add_row(8, "stall_next", 3, 4, 2, 3, floo_noc_pkg::WideB, 5'h11,
            {OK, OK, OK, OK, OK}, 5'h00, 0, 7, 4, 0, 5'h11, 0);
    add_row(9, "b2b_first", 2, 3, 2, 3, floo_noc_pkg::WideB, 5'h1F,
            {ER, OK, ER, OK, OK}, 5'h00, 0, 7, 0, 1, 5'h1F, 2);
    add_row(10, "b2b_second", 4, 3, 2, 3, floo_noc_pkg::NarrowB, 5'h1F,
            {OK, OK, OK, OK, OK}, 5'h00, 0, 7, 0, 1, 5'h1D, 0);
    add_row(11, "b2b_third", 2, 0, 0, 0, floo_noc_pkg::NarrowB, 5'h0B,
            {OK, OK, OK, OK, ER}, 5'h00, 0, 7, 0, 1, 5'h0B, 0);

    // Table entries against the model
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_err[r] = 0;
      m = expected_routes(tbl[r].xy, tbl[r].flit[lead_route(tbl[r].valid)].hdr);
      w = merge_pick(tbl[r], m);
      if (m !== tbl[r].exp_mask) value_error(row_name[r], r, "table mask", m, tbl[r].exp_mask);
      if (w != int'(tbl[r].exp_route)) begin
        value_error(row_name[r], r, "table merge route", w, tbl[r].exp_route);
      end
    end

    reset_err = err_cnt;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (valid_o !== 1'b0) value_error("reset", -1, "valid_o in reset", 0, valid_o);
    if (ready_o !== '0) value_error("reset", -1, "ready_o in reset", 0, ready_o);
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    if (valid_o !== 1'b0) value_error("reset", -1, "valid_o after reset", 0, valid_o);
    if (ready_o !== '0) value_error("reset", -1, "ready_o after reset", 0, ready_o);
    close_test("reset", err_cnt == reset_err);
    @(posedge clk_i);

    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
    end
    valid_i <= '0;
    while (pend_q.size() != 0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_pass, tests_run - tests_pass, err_cnt);
    if ((err_cnt == 0) && (tests_run == NUM_ROWS + 1)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog/floo_reduction_unit.sv */
/*
 * B-response reduction for one router output toward the initiator.
 * Combinational merge followed by one register stage, one cycle latency.
 */
`timescale 1ns/1ps
`include "floo_red_macros.svh"

module floo_reduction_unit (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  // Coordinate of this router
  input  floo_noc_pkg::coord_t                           xy_id_i,
  // Input routes N, E, S, W, L
  input  logic                [`FLOO_RED_NUM_ROUTES-1:0] valid_i,
  output logic                [`FLOO_RED_NUM_ROUTES-1:0] ready_o,
  input  floo_noc_pkg::flit_t [`FLOO_RED_NUM_ROUTES-1:0] data_i,
  // Merged response toward the initiator
  output logic                                           valid_o,
  input  logic                                           ready_i,
  output floo_noc_pkg::flit_t                            data_o
);

  // Arbiter to register channel
  logic                red_valid;
  logic                red_ready;
  floo_noc_pkg::flit_t red_data;

  floo_reduction_arbiter i_arbiter (
    .xy_id_i(xy_id_i),
    .valid_i(valid_i),
    .ready_o(ready_o),
    .data_i (data_i),
    .valid_o(red_valid),
    .ready_i(red_ready),
    .data_o (red_data)
  );

  floo_reduction_out_reg #(
    .data_t(floo_noc_pkg::flit_t)
  ) i_out_reg (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (red_valid),
    .ready_o (red_ready),
    .data_i  (red_data),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

endmodule

/* verilog/floo_reduction_out_reg.sv */
/*
 * One-entry valid/ready pipeline register for any packed payload.
 * Full throughput: a new entry is taken in the cycle the old one leaves.
 * ready_o depends combinationally on ready_i.
 */
`timescale 1ns/1ps

module floo_reduction_out_reg #(
  // Payload carried through the stage
  parameter type data_t = logic
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  logic  full_q;
  data_t data_q;

  // Room when empty or when the held entry leaves now
  assign ready_o = !full_q || ready_i;

  // Occupancy flag
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      // Refill or drain
      full_q <= valid_i;
    end
  end

  // Payload loads only on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  // Held steady while stalled
  assign data_o  = data_q;

endmodule

/* verilog/floo_reduction_arbiter.sv */
/*
 * Merges the expected B flits of one multicast into a single flit.
 * Combinational. SLVERR from any expected route wins, lowest index first;
 * otherwise the lowest-index expected flit passes. Inputs are acked only
 * in the cycle the merged flit is taken downstream.
 */
`timescale 1ns/1ps
`include "floo_red_macros.svh"

module floo_reduction_arbiter (
  input  floo_noc_pkg::coord_t                           xy_id_i,
  // Router input routes
  input  logic                [`FLOO_RED_NUM_ROUTES-1:0] valid_i,
  output logic                [`FLOO_RED_NUM_ROUTES-1:0] ready_o,
  input  floo_noc_pkg::flit_t [`FLOO_RED_NUM_ROUTES-1:0] data_i,
  // Merged output
  output logic                                           valid_o,
  input  logic                                           ready_i,
  output floo_noc_pkg::flit_t                            data_o
);

  floo_noc_pkg::route_e              lead_idx;
  logic [`FLOO_RED_NUM_ROUTES-1:0]   route_mask;
  logic [`FLOO_RED_PAYLOAD_W-1:0]    rsp_mask;
  floo_resp_pkg::resp_t              rsp [`FLOO_RED_NUM_ROUTES];
  logic                              first_found;
  logic                              err_found;

  // Gather the masked payload bits into a response code, LSB first
  function automatic floo_resp_pkg::resp_t extract_resp(
    input logic [`FLOO_RED_PAYLOAD_W-1:0] payload,
    input logic [`FLOO_RED_PAYLOAD_W-1:0] mask
  );
    floo_resp_pkg::resp_t resp;
    int unsigned          j;
    resp = '0;
    j = 0;
    for (int k = 0; k < `FLOO_RED_PAYLOAD_W; k++) begin
      if (mask[k] && (j < $bits(floo_resp_pkg::resp_t))) begin
        resp[j] = payload[k];
        j++;
      end
    end
    return resp;
  endfunction

  // Priority search for the lowest-index valid input
  always_comb begin
    lead_idx = floo_noc_pkg::North;
    for (int i = `FLOO_RED_NUM_ROUTES - 1; i >= 0; i--) begin
      if (valid_i[i]) begin
        lead_idx = floo_noc_pkg::route_e'(i);
      end
    end
  end

  floo_reduction_sync i_sync (
    .xy_id_i      (xy_id_i),
    .lead_hdr_i   (data_i[lead_idx].hdr),
    .valid_i      (valid_i),
    .data_i       (data_i),
    .route_mask_o (route_mask),
    .all_arrived_o(valid_o)
  );

  // Response field position depends on the channel
  assign rsp_mask = (data_i[lead_idx].hdr.axi_ch == floo_noc_pkg::NarrowB) ?
                    `FLOO_RED_NARROW_RSP_MASK : `FLOO_RED_WIDE_RSP_MASK;

  always_comb begin
    for (int i = 0; i < `FLOO_RED_NUM_ROUTES; i++) begin
      rsp[i] = extract_resp(data_i[i].payload, rsp_mask);
    end
  end

  // Error-priority merge over the expected routes
  always_comb begin
    data_o      = data_i[lead_idx];
    first_found = 1'b0;
    err_found   = 1'b0;
    for (int i = 0; i < `FLOO_RED_NUM_ROUTES; i++) begin
      if (route_mask[i]) begin
        // Default pick is the first expected route
        if (!first_found) begin
          data_o      = data_i[i];
          first_found = 1'b1;
        end
        // First SLVERR overrides and sticks
        if (!err_found && (rsp[i] == floo_resp_pkg::RESP_SLVERR)) begin
          data_o    = data_i[i];
          err_found = 1'b1;
        end
      end
    end
  end

  // Ack the whole group together with the output transfer
  assign ready_o = (valid_o && ready_i) ? route_mask : '0;

endmodule

/* verilog/floo_reduction_sync.sv */
/*
 * Expected-route mask under XY routing plus the all-arrived check.
 * Purely combinational. The leading header must come from a valid input.
 * An empty mask never reports arrival, so such a flit waits forever.
 */
`timescale 1ns/1ps
`include "floo_red_macros.svh"

module floo_reduction_sync (
  // Coordinate of this router
  input  floo_noc_pkg::coord_t                             xy_id_i,
  // Header of the lowest-index valid input
  input  floo_noc_pkg::hdr_t                               lead_hdr_i,
  input  logic                  [`FLOO_RED_NUM_ROUTES-1:0] valid_i,
  input  floo_noc_pkg::flit_t   [`FLOO_RED_NUM_ROUTES-1:0] data_i,
  // Routes that must deliver a response
  output logic                  [`FLOO_RED_NUM_ROUTES-1:0] route_mask_o,
  output logic                                             all_arrived_o
);

  floo_noc_pkg::coord_t  src;
  floo_noc_pkg::region_t rgn;
  logic                  in_x_range;
  logic                  in_y_range;
  logic                  missing;

  assign src = lead_hdr_i.src_id;
  assign rgn = lead_hdr_i.region;

  // Router column and row against the rectangle
  assign in_x_range = (xy_id_i.x >= rgn.x_lo) && (xy_id_i.x <= rgn.x_hi);
  assign in_y_range = (xy_id_i.y >= rgn.y_lo) && (xy_id_i.y <= rgn.y_hi);

  always_comb begin
    route_mask_o = '0;

    // Own tile is a target
    route_mask_o[floo_noc_pkg::Local] = in_x_range && in_y_range;

    if (xy_id_i.y == src.y) begin
      // Source row
      // XY routing spreads along X first
      route_mask_o[floo_noc_pkg::East] = rgn.x_hi > xy_id_i.x;
      route_mask_o[floo_noc_pkg::West] = rgn.x_lo < xy_id_i.x;
      // Column branches only leave from inside the X range
      route_mask_o[floo_noc_pkg::North] = (rgn.y_hi > xy_id_i.y) && in_x_range;
      route_mask_o[floo_noc_pkg::South] = (rgn.y_lo < xy_id_i.y) && in_x_range;
    end else if (xy_id_i.y > src.y) begin
      // Above the source row
      // Only the column continues upward
      route_mask_o[floo_noc_pkg::North] = rgn.y_hi > xy_id_i.y;
    end else begin
      // Below the source row
      route_mask_o[floo_noc_pkg::South] = rgn.y_lo < xy_id_i.y;
    end
  end

  // An expected route is missing if idle or holding another transaction
  always_comb begin
    missing = 1'b0;
    for (int i = 0; i < `FLOO_RED_NUM_ROUTES; i++) begin
      if (route_mask_o[i]) begin
        if (!valid_i[i] || (data_i[i].hdr.txn_id != lead_hdr_i.txn_id)) begin
          missing = 1'b1;
        end
      end
    end
  end

  // Needs a non-empty expected set with no route missing
  assign all_arrived_o = (|route_mask_o) && !missing;

endmodule

/* verilog/floo_resp_pkg.sv */
/*
 * AXI write response codes as used by the reduction merge.
 * Only SLVERR is treated as an error by the merge; DECERR passes as data.
 */
package floo_resp_pkg;

  // Two-bit AXI BRESP / RRESP code
  typedef logic [1:0] resp_t;

  // Normal access done
  localparam resp_t RESP_OKAY   = 2'b00;

  // Exclusive access done
  localparam resp_t RESP_EXOKAY = 2'b01;

  // Subordinate reported an error
  // Wins the merge
  localparam resp_t RESP_SLVERR = 2'b10;

  // No subordinate at the address
  localparam resp_t RESP_DECERR = 2'b11;

endpackage

/* verilog/floo_noc_pkg.sv */
/*
 * Flit and header types of the mesh NoC as seen by the reduction stage.
 * Only B channels are modeled; the payload is opaque apart from the
 * response field picked out by the channel mask.
 */
`include "floo_red_macros.svh"

package floo_noc_pkg;

  // Input route index
  // Order matches the bit order of every route vector
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } route_e;

  // Tile coordinate in the mesh
  typedef struct packed {
    logic [`FLOO_RED_COORD_W-1:0] x;
    logic [`FLOO_RED_COORD_W-1:0] y;
  } coord_t;

  // Multicast rectangle, bounds inclusive
  typedef struct packed {
    logic [`FLOO_RED_COORD_W-1:0] x_lo;
    logic [`FLOO_RED_COORD_W-1:0] x_hi;
    logic [`FLOO_RED_COORD_W-1:0] y_lo;
    logic [`FLOO_RED_COORD_W-1:0] y_hi;
  } region_t;

  // Which B channel the flit belongs to
  // Selects the response mask
  typedef enum logic {
    NarrowB = 1'b0,
    WideB   = 1'b1
  } axi_ch_e;

  // Routing header carried by every flit
  typedef struct packed {
    // Initiator of the multicast write
    coord_t     src_id;
    region_t    region;
    logic [3:0] txn_id;
    axi_ch_e    axi_ch;
  } hdr_t;

  // Header first, then payload
  typedef struct packed {
    hdr_t                           hdr;
    logic [`FLOO_RED_PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

/* verilog/floo_red_macros.svh */
/*
 * Shared sizing for the B-response reduction stage of one mesh router port.
 * Route order is fixed as North, East, South, West, Local.
 * The response masks must each select exactly two payload bits.
 */
`ifndef FLOO_RED_MACROS_SVH
`define FLOO_RED_MACROS_SVH

// Input routes of one router
// Sets valid, ready and route mask widths
`define FLOO_RED_NUM_ROUTES 5

// Width of one X or Y mesh coordinate
// 3 bits covers an 8x8 mesh
`define FLOO_RED_COORD_W 3

// Flit payload width in bits
`define FLOO_RED_PAYLOAD_W 16

// Narrow B response code sits in payload bits 1:0
`define FLOO_RED_NARROW_RSP_MASK 16'h0003

// Wide B response code sits in payload bits 9:8
`define FLOO_RED_WIDE_RSP_MASK 16'h0300

`endif
